// ==== commit_arbiter.sv ====
`timescale 1ns/100ps

module commit_arbiter #(
    parameter int XLEN = 32
) (
    input  logic                             excp0_i,
    input  logic                             excp1_i,
    input  commit_pkg::cause_t               cause0_i,
    input  commit_pkg::cause_t               cause1_i,
    input  logic [XLEN-1:0]                  pc0_i,
    input  logic [XLEN-1:0]                  pc1_i,
    input  logic [XLEN-1:0]                  addr0_i,
    input  logic [XLEN-1:0]                  addr1_i,
    input  logic                             ertn_i,
    input  logic                             refetch_i,
    input  logic                             branch_flush_i,
    input  logic                             ex_flush_i,
    input  logic [XLEN-1:0]                  eentry_i,
    input  logic [XLEN-1:0]                  tlbrentry_i,
    input  logic [XLEN-1:0]                  era_i,
    input  logic [XLEN-1:0]                  refetch_pc_i,
    input  logic [XLEN-1:0]                  branch_pc_i,
    output logic [1:0]                       excp_o,
    output logic                             is_exception_o,
    output commit_pkg::cause_t               cause_o,
    output logic [commit_pkg::ECODE_W-1:0]   ecode_o,
    output logic [commit_pkg::ESUB_W-1:0]    esub_o,
    output logic [XLEN-1:0]                  excp_pc_o,
    output logic [XLEN-1:0]                  excp_addr_o,
    output logic [XLEN-1:0]                  new_pc_o,
    output logic [commit_pkg::N_STAGE-1:0]   flush_o,
    output logic                             front_flush_o
);

    logic flush_front;  // pc, icache, instbuffer
    logic flush_mid;    // decode, dispatch
    logic flush_back;   // execute, mem, wb

    assign excp_o         = {excp1_i, excp0_i};
    assign is_exception_o = excp0_i || excp1_i;

    // older slot wins when both trap
    assign cause_o     = excp0_i ? cause0_i : cause1_i;
    assign excp_pc_o   = excp0_i ? pc0_i    : pc1_i;
    assign excp_addr_o = excp0_i ? addr0_i  : addr1_i;
    assign ecode_o     = commit_pkg::cause_to_ecode(cause_o);
    assign esub_o      = commit_pkg::cause_to_esub(cause_o);

    always_comb begin
        if (is_exception_o) begin
            new_pc_o = (cause_o == commit_pkg::CAUSE_TLBR) ? tlbrentry_i : eentry_i;
        end else if (ertn_i) begin
            new_pc_o = era_i;
        end else if (refetch_i) begin
            new_pc_o = refetch_pc_i;  // replay after csr write, idle, ll/sc
        end else begin
            new_pc_o = branch_pc_i;
        end
    end

    always_comb begin
        flush_back  = is_exception_o || ertn_i || refetch_i;
        flush_front = flush_back || branch_flush_i;   // branch leaves ex and later alone
        flush_mid   = flush_front || ex_flush_i;

        flush_o       = {{3{flush_back}}, {2{flush_mid}}, {3{flush_front}}};
        front_flush_o = flush_o[1];  // icache
    end

endmodule

// ==== commit_pkg.sv ====
package commit_pkg;

    localparam int ECODE_W    = 6;
    localparam int ESUB_W     = 9;
    localparam int N_SRC      = 6;  // stage fault flags per slot
    localparam int N_STAGE    = 8;  // pc, icache, ibuf, decode, dispatch, ex, mem, wb
    localparam int CSR_ADDR_W = 14;
    localparam int REG_ADDR_W = 5;

    // internal cause codes, carried down the pipe with each instruction
    typedef enum logic [6:0] {
        CAUSE_INT  = 7'd0,
        CAUSE_PIL  = 7'd1,
        CAUSE_PIS  = 7'd2,
        CAUSE_PIF  = 7'd3,
        CAUSE_PME  = 7'd4,
        CAUSE_PPI  = 7'd5,
        CAUSE_ADEF = 7'd6,
        CAUSE_ADEM = 7'd7,
        CAUSE_ALE  = 7'd8,
        CAUSE_SYS  = 7'd9,
        CAUSE_BRK  = 7'd10,
        CAUSE_INE  = 7'd11,
        CAUSE_IPE  = 7'd12,
        CAUSE_FPD  = 7'd13,
        CAUSE_FPE  = 7'd14,
        CAUSE_TLBR = 7'd15,
        CAUSE_NOP  = 7'd16
    } cause_t;

    // architectural ecode as written to estat
    function automatic logic [ECODE_W-1:0] cause_to_ecode(input cause_t cause);
        case (cause)
            CAUSE_INT:  return 6'h00;
            CAUSE_PIL:  return 6'h01;
            CAUSE_PIS:  return 6'h02;
            CAUSE_PIF:  return 6'h03;
            CAUSE_PME:  return 6'h04;
            CAUSE_PPI:  return 6'h07;
            CAUSE_ADEF: return 6'h08;
            CAUSE_ADEM: return 6'h08;  // same code, told apart by esubcode
            CAUSE_ALE:  return 6'h09;
            CAUSE_SYS:  return 6'h0b;
            CAUSE_BRK:  return 6'h0c;
            CAUSE_INE:  return 6'h0d;
            CAUSE_IPE:  return 6'h0e;
            CAUSE_FPD:  return 6'h0f;
            CAUSE_FPE:  return 6'h12;
            CAUSE_TLBR: return 6'h3f;
            default:    return 6'h00;
        endcase
    endfunction

    function automatic logic [ESUB_W-1:0] cause_to_esub(input cause_t cause);
        return (cause == CAUSE_ADEM) ? 9'd1 : 9'd0;  // only adem has a subcode
    endfunction

endpackage

// ==== commit_unit.sv ====
`timescale 1ns/100ps

module commit_unit #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rst,
    // per slot, slot 0 is older
    input  logic                              valid0_i,
    input  logic                              valid1_i,
    input  logic [commit_pkg::N_SRC-1:0]      flags0_i,
    input  logic [commit_pkg::N_SRC-1:0]      flags1_i,
    input  commit_pkg::cause_t                pc_cause0_i,
    input  commit_pkg::cause_t                pc_cause1_i,
    input  commit_pkg::cause_t                ibuf_cause0_i,
    input  commit_pkg::cause_t                ibuf_cause1_i,
    input  commit_pkg::cause_t                dec_cause0_i,
    input  commit_pkg::cause_t                dec_cause1_i,
    input  commit_pkg::cause_t                disp_cause0_i,
    input  commit_pkg::cause_t                disp_cause1_i,
    input  commit_pkg::cause_t                ex_cause0_i,
    input  commit_pkg::cause_t                ex_cause1_i,
    input  commit_pkg::cause_t                cmt_cause0_i,
    input  commit_pkg::cause_t                cmt_cause1_i,
    input  logic                              privileged0_i,
    input  logic                              privileged1_i,
    input  logic [XLEN-1:0]                   pc0_i,
    input  logic [XLEN-1:0]                   pc1_i,
    input  logic [XLEN-1:0]                   addr0_i,
    input  logic [XLEN-1:0]                   addr1_i,
    input  logic [1:0]                        llsc_i,
    input  logic [1:0]                        csr_we_i,
    input  logic [commit_pkg::CSR_ADDR_W-1:0] csr_addr0_i,
    input  logic [commit_pkg::CSR_ADDR_W-1:0] csr_addr1_i,
    input  logic [XLEN-1:0]                   csr_data0_i,
    input  logic [XLEN-1:0]                   csr_data1_i,
    input  logic [1:0]                        rf_we_i,
    input  logic [commit_pkg::REG_ADDR_W-1:0] rf_addr0_i,
    input  logic [commit_pkg::REG_ADDR_W-1:0] rf_addr1_i,
    input  logic [XLEN-1:0]                   rf_data0_i,
    input  logic [XLEN-1:0]                   rf_data1_i,
    input  logic                              idle0_i,
    // shared
    input  logic [1:0]                        crmd_plv_i,
    input  logic                              interrupt_i,
    input  logic                              ertn0_i,
    input  logic                              branch_flush_i,
    input  logic [XLEN-1:0]                   branch_pc_i,
    input  logic                              ex_flush_i,
    input  logic [XLEN-1:0]                   eentry_i,
    input  logic [XLEN-1:0]                   tlbrentry_i,
    input  logic [XLEN-1:0]                   era_i,
    input  logic [XLEN-1:0]                   refetch_pc_i,
    input  logic                              pause_decode_i,
    input  logic                              pause_dispatch_i,
    input  logic                              pause_execute_i,
    input  logic                              pause_mem_i,
    // to csr file
    output logic                              is_exception_o,
    output commit_pkg::cause_t                excp_cause_o,
    output logic [commit_pkg::ECODE_W-1:0]    ecode_o,
    output logic [commit_pkg::ESUB_W-1:0]     esub_o,
    output logic [XLEN-1:0]                   excp_pc_o,
    output logic [XLEN-1:0]                   excp_addr_o,
    output logic                              csr_we_o,
    output logic [commit_pkg::CSR_ADDR_W-1:0] csr_addr_o,
    output logic [XLEN-1:0]                   csr_data_o,
    output logic                              llsc_o,
    // to regfile
    output logic [1:0]                        rf_we_o,
    output logic [commit_pkg::REG_ADDR_W-1:0] rf_addr0_o,
    output logic [commit_pkg::REG_ADDR_W-1:0] rf_addr1_o,
    output logic [XLEN-1:0]                   rf_data0_o,
    output logic [XLEN-1:0]                   rf_data1_o,
    // pipeline control
    output logic [XLEN-1:0]                   new_pc_o,
    output logic [commit_pkg::N_STAGE-1:0]    flush_o,
    output logic [commit_pkg::N_STAGE-1:0]    pause_o
);

    logic               excp0;
    logic               excp1;
    commit_pkg::cause_t cause0;
    commit_pkg::cause_t cause1;
    logic [1:0]         excp;
    logic               refetch;
    logic               front_flush;

    slot_cause_encoder #(.XLEN(XLEN)) enc0_i (
        .valid_i(valid0_i), .flags_i(flags0_i), .interrupt_i(interrupt_i),
        .pc_cause_i(pc_cause0_i), .ibuf_cause_i(ibuf_cause0_i), .dec_cause_i(dec_cause0_i),
        .disp_cause_i(disp_cause0_i), .ex_cause_i(ex_cause0_i), .cmt_cause_i(cmt_cause0_i),
        .privileged_i(privileged0_i), .plv_i(crmd_plv_i),
        .excp_o(excp0), .cause_o(cause0)
    );

    slot_cause_encoder #(.XLEN(XLEN)) enc1_i (
        .valid_i(valid1_i), .flags_i(flags1_i), .interrupt_i(interrupt_i),
        .pc_cause_i(pc_cause1_i), .ibuf_cause_i(ibuf_cause1_i), .dec_cause_i(dec_cause1_i),
        .disp_cause_i(disp_cause1_i), .ex_cause_i(ex_cause1_i), .cmt_cause_i(cmt_cause1_i),
        .privileged_i(privileged1_i), .plv_i(crmd_plv_i),
        .excp_o(excp1), .cause_o(cause1)
    );

    commit_arbiter #(.XLEN(XLEN)) arb_i (
        .excp0_i(excp0), .excp1_i(excp1), .cause0_i(cause0), .cause1_i(cause1),
        .pc0_i(pc0_i), .pc1_i(pc1_i), .addr0_i(addr0_i), .addr1_i(addr1_i),
        .ertn_i(ertn0_i), .refetch_i(refetch), .branch_flush_i(branch_flush_i),
        .ex_flush_i(ex_flush_i), .eentry_i(eentry_i), .tlbrentry_i(tlbrentry_i),
        .era_i(era_i), .refetch_pc_i(refetch_pc_i), .branch_pc_i(branch_pc_i),
        .excp_o(excp), .is_exception_o(is_exception_o), .cause_o(excp_cause_o),
        .ecode_o(ecode_o), .esub_o(esub_o), .excp_pc_o(excp_pc_o),
        .excp_addr_o(excp_addr_o), .new_pc_o(new_pc_o), .flush_o(flush_o),
        .front_flush_o(front_flush)
    );

    retire_gate #(.XLEN(XLEN)) gate_i (
        .excp_i(excp), .pause_mem_i(pause_mem_i),
        .rf_we_i(rf_we_i), .rf_addr0_i(rf_addr0_i), .rf_addr1_i(rf_addr1_i),
        .rf_data0_i(rf_data0_i), .rf_data1_i(rf_data1_i),
        .csr_we_i(csr_we_i), .csr_addr0_i(csr_addr0_i), .csr_addr1_i(csr_addr1_i),
        .csr_data0_i(csr_data0_i), .csr_data1_i(csr_data1_i),
        .llsc_i(llsc_i), .idle0_i(idle0_i),
        .rf_we_o(rf_we_o), .rf_addr0_o(rf_addr0_o), .rf_addr1_o(rf_addr1_o),
        .rf_data0_o(rf_data0_o), .rf_data1_o(rf_data1_o),
        .csr_we_o(csr_we_o), .csr_addr_o(csr_addr_o), .csr_data_o(csr_data_o),
        .llsc_o(llsc_o), .refetch_o(refetch)
    );

    stall_ctrl stall_i (
        .clk(clk), .rst(rst),
        .pause_decode_i(pause_decode_i), .pause_dispatch_i(pause_dispatch_i),
        .pause_execute_i(pause_execute_i), .pause_mem_i(pause_mem_i),
        .idle0_i(idle0_i), .interrupt_i(interrupt_i),
        .front_flush_i(front_flush), .pause_o(pause_o)
    );

endmodule

// ==== project.f ====
commit_pkg.sv
slot_cause_encoder.sv
commit_arbiter.sv
retire_gate.sv
stall_ctrl.sv
commit_unit.sv
tb_commit_unit.sv

// ==== retire_gate.sv ====
`timescale 1ns/100ps

module retire_gate #(
    parameter int XLEN = 32
) (
    input  logic [1:0]                        excp_i,
    input  logic                              pause_mem_i,
    input  logic [1:0]                        rf_we_i,
    input  logic [commit_pkg::REG_ADDR_W-1:0] rf_addr0_i,
    input  logic [commit_pkg::REG_ADDR_W-1:0] rf_addr1_i,
    input  logic [XLEN-1:0]                   rf_data0_i,
    input  logic [XLEN-1:0]                   rf_data1_i,
    input  logic [1:0]                        csr_we_i,
    input  logic [commit_pkg::CSR_ADDR_W-1:0] csr_addr0_i,
    input  logic [commit_pkg::CSR_ADDR_W-1:0] csr_addr1_i,
    input  logic [XLEN-1:0]                   csr_data0_i,
    input  logic [XLEN-1:0]                   csr_data1_i,
    input  logic [1:0]                        llsc_i,
    input  logic                              idle0_i,
    output logic [1:0]                        rf_we_o,
    output logic [commit_pkg::REG_ADDR_W-1:0] rf_addr0_o,
    output logic [commit_pkg::REG_ADDR_W-1:0] rf_addr1_o,
    output logic [XLEN-1:0]                   rf_data0_o,
    output logic [XLEN-1:0]                   rf_data1_o,
    output logic                              csr_we_o,
    output logic [commit_pkg::CSR_ADDR_W-1:0] csr_addr_o,
    output logic [XLEN-1:0]                   csr_data_o,
    output logic                              llsc_o,
    output logic                              refetch_o
);

    logic any_excp;

    assign any_excp = |excp_i;

    always_comb begin
        rf_we_o[0] = rf_we_i[0] && !excp_i[0] && !pause_mem_i;
        rf_we_o[1] = rf_we_i[1] && !any_excp && !pause_mem_i;  // younger dies with either
        if (rf_we_o[1] && rf_addr0_i == rf_addr1_i) begin
            rf_we_o[0] = 1'b0;  // younger result is the one that survives
        end
    end

    assign rf_addr0_o = rf_addr0_i;
    assign rf_addr1_o = rf_addr1_i;
    assign rf_data0_o = rf_data0_i;
    assign rf_data1_o = rf_data1_i;

    assign csr_we_o   = (|csr_we_i) && !any_excp;
    assign csr_addr_o = csr_we_i[0] ? csr_addr0_i : csr_addr1_i;
    assign csr_data_o = csr_we_i[0] ? csr_data0_i : csr_data1_i;
    assign llsc_o     = (|llsc_i) && !any_excp;

    // state the front end may have read stale, so fetch again
    assign refetch_o = csr_we_o || idle0_i || llsc_i[0];

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module tb_commit_unit -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q '^\*\*\* PASSED \*\*\*$'

// ==== slot_cause_encoder.sv ====
`timescale 1ns/100ps

module slot_cause_encoder #(
    parameter int XLEN = 32
) (
    input  logic                         valid_i,
    input  logic [commit_pkg::N_SRC-1:0] flags_i,       // [5] pc .. [0] commit
    input  logic                         interrupt_i,
    input  commit_pkg::cause_t           pc_cause_i,
    input  commit_pkg::cause_t           ibuf_cause_i,
    input  commit_pkg::cause_t           dec_cause_i,
    input  commit_pkg::cause_t           disp_cause_i,
    input  commit_pkg::cause_t           ex_cause_i,
    input  commit_pkg::cause_t           cmt_cause_i,
    input  logic                         privileged_i,
    input  logic [1:0]                   plv_i,
    output logic                         excp_o,
    output commit_pkg::cause_t           cause_o
);

    // only 32 and 64 bit datapaths have defined exception entries
    if (XLEN != 32 && XLEN != 64) begin : g_xlen_check
        $error("slot_cause_encoder: unsupported XLEN %0d", XLEN);
    end

    always_comb begin
        excp_o = valid_i && (interrupt_i || (|flags_i));

        if (interrupt_i) begin
            cause_o = commit_pkg::CAUSE_INT;
        end else if (flags_i[5]) begin
            cause_o = pc_cause_i;              // fetch side first
        end else if (flags_i[4]) begin
            cause_o = ibuf_cause_i;
        end else if (flags_i[3]) begin
            // privileged op outside plv0 overrides whatever decode reported
            cause_o = (privileged_i && plv_i != 2'b00) ? commit_pkg::CAUSE_IPE : dec_cause_i;
        end else if (flags_i[2]) begin
            cause_o = disp_cause_i;
        end else if (flags_i[1]) begin
            cause_o = ex_cause_i;
        end else if (flags_i[0]) begin
            cause_o = cmt_cause_i;
        end else begin
            cause_o = commit_pkg::CAUSE_NOP;
        end

        // a raised stage flag must carry a real cause from upstream
        assert (!excp_o || cause_o != commit_pkg::CAUSE_NOP)
            else $error("slot_cause_encoder: trap with NOP cause");
    end

endmodule

// ==== stall_ctrl.sv ====
`timescale 1ns/100ps

module stall_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pause_decode_i,
    input  logic                           pause_dispatch_i,
    input  logic                           pause_execute_i,
    input  logic                           pause_mem_i,
    input  logic                           idle0_i,
    input  logic                           interrupt_i,
    input  logic                           front_flush_i,
    output logic [commit_pkg::N_STAGE-1:0] pause_o
);

    logic       idle_lock;  // front end parked after idle
    logic [4:0] pause_back;

    always_ff @(posedge clk) begin
        if (rst) begin
            idle_lock <= 1'b0;
        end else if (idle0_i && !interrupt_i) begin
            idle_lock <= 1'b1;
        end else if (interrupt_i) begin
            idle_lock <= 1'b0;  // only an interrupt wakes the core
        end
    end

    // deepest stall holds everything above it
    always_comb begin
        pause_back[4] = pause_mem_i;
        pause_back[3] = pause_mem_i || pause_execute_i;
        pause_back[2] = pause_mem_i || pause_execute_i || pause_dispatch_i;
        pause_back[1] = pause_back[2] || pause_decode_i;
        pause_back[0] = pause_decode_i;
    end

    assign pause_o = {pause_back, pause_decode_i, idle_lock && !front_flush_i, idle_lock};

    a_int_wakes: assert property (@(posedge clk) disable iff (rst)
        interrupt_i |=> !idle_lock)
        else $error("stall_ctrl: idle lock held after interrupt");

endmodule

// ==== tb_commit_unit.sv ====
`timescale 1ns/100ps

module tb_commit_unit;

    localparam int XLEN = 32;

    logic clk = 1'b0;
    logic rst;
    logic valid0_i, valid1_i, privileged0_i, privileged1_i, idle0_i;
    logic [5:0] flags0_i, flags1_i;
    commit_pkg::cause_t pc_cause0_i, pc_cause1_i, ibuf_cause0_i, ibuf_cause1_i;
    commit_pkg::cause_t dec_cause0_i, dec_cause1_i, disp_cause0_i, disp_cause1_i;
    commit_pkg::cause_t ex_cause0_i, ex_cause1_i, cmt_cause0_i, cmt_cause1_i;
    logic [31:0] pc0_i, pc1_i, addr0_i, addr1_i, csr_data0_i, csr_data1_i;
    logic [31:0] rf_data0_i, rf_data1_i, branch_pc_i, eentry_i, tlbrentry_i, era_i;
    logic [31:0] refetch_pc_i;
    logic [1:0] llsc_i, csr_we_i, rf_we_i, crmd_plv_i;
    logic [13:0] csr_addr0_i, csr_addr1_i;
    logic [4:0] rf_addr0_i, rf_addr1_i;
    logic interrupt_i, ertn0_i, branch_flush_i, ex_flush_i;
    logic pause_decode_i, pause_dispatch_i, pause_execute_i, pause_mem_i;
    logic is_exception_o, csr_we_o, llsc_o;
    commit_pkg::cause_t excp_cause_o;
    logic [5:0] ecode_o;
    logic [8:0] esub_o;
    logic [31:0] excp_pc_o, excp_addr_o, csr_data_o, rf_data0_o, rf_data1_o, new_pc_o;
    logic [13:0] csr_addr_o;
    logic [1:0] rf_we_o;
    logic [4:0] rf_addr0_o, rf_addr1_o;
    logic [7:0] flush_o, pause_o;

    int errors = 0;
    int tests = 0;
    logic [31:0] seed = 32'h7600_df97;
    commit_pkg::cause_t rc [6];  // pc, ibuf, dec, disp, ex, cmt causes for slot 0

    commit_unit #(.XLEN(XLEN)) dut_i (.*);

    always #20 clk = ~clk;

    initial begin
        #200us;
        $display("timeout: simulation did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // reference priority: interrupt, pc, ibuf, decode (ipe), dispatch, ex, commit
    function automatic commit_pkg::cause_t expected_cause(logic intr, logic [5:0] fl,
                                                          logic priv, logic [1:0] plv);
        if (intr) return commit_pkg::CAUSE_INT;
        if (fl[5]) return rc[0];
        if (fl[4]) return rc[1];
        if (fl[3]) return (priv && plv != 2'd0) ? commit_pkg::CAUSE_IPE : rc[2];
        if (fl[2]) return rc[3];
        if (fl[1]) return rc[4];
        if (fl[0]) return rc[5];
        return commit_pkg::CAUSE_NOP;
    endfunction

    function automatic logic [31:0] expected_ecode(commit_pkg::cause_t c);
        case (c)
            commit_pkg::CAUSE_PIL:  return 32'h01;
            commit_pkg::CAUSE_PIS:  return 32'h02;
            commit_pkg::CAUSE_PIF:  return 32'h03;
            commit_pkg::CAUSE_PME:  return 32'h04;
            commit_pkg::CAUSE_PPI:  return 32'h07;
            commit_pkg::CAUSE_ADEF, commit_pkg::CAUSE_ADEM: return 32'h08;
            commit_pkg::CAUSE_ALE:  return 32'h09;
            commit_pkg::CAUSE_SYS:  return 32'h0b;
            commit_pkg::CAUSE_BRK:  return 32'h0c;
            commit_pkg::CAUSE_INE:  return 32'h0d;
            commit_pkg::CAUSE_IPE:  return 32'h0e;
            commit_pkg::CAUSE_FPD:  return 32'h0f;
            commit_pkg::CAUSE_FPE:  return 32'h12;
            commit_pkg::CAUSE_TLBR: return 32'h3f;
            default:                return 32'h00;
        endcase
    endfunction

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act)
            else begin
                $display("ERROR %s: expected %h, actual %h", name, exp, act);
                errors++;
            end
    endtask

    task automatic report(string name, int errs_before);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errs_before);
    endtask

    // called right after a rising edge, so all drives are non-blocking
    task automatic clear_inputs();
        {valid0_i, valid1_i, privileged0_i, privileged1_i, idle0_i} <= '0;
        {flags0_i, flags1_i, llsc_i, csr_we_i, rf_we_i, crmd_plv_i} <= '0;
        {pc_cause0_i, ibuf_cause0_i, dec_cause0_i} <= {3{commit_pkg::CAUSE_NOP}};
        {disp_cause0_i, ex_cause0_i, cmt_cause0_i} <= {3{commit_pkg::CAUSE_NOP}};
        {pc_cause1_i, ibuf_cause1_i, dec_cause1_i} <= {3{commit_pkg::CAUSE_NOP}};
        {disp_cause1_i, ex_cause1_i, cmt_cause1_i} <= {3{commit_pkg::CAUSE_NOP}};
        {pc0_i, pc1_i, addr0_i, addr1_i, csr_data0_i, csr_data1_i} <= '0;
        {rf_data0_i, rf_data1_i, branch_pc_i, eentry_i, tlbrentry_i} <= '0;
        {era_i, refetch_pc_i, csr_addr0_i, csr_addr1_i, rf_addr0_i, rf_addr1_i} <= '0;
        {interrupt_i, ertn0_i, branch_flush_i, ex_flush_i} <= '0;
        {pause_decode_i, pause_dispatch_i, pause_execute_i, pause_mem_i} <= '0;
    endtask

    task automatic cause_case(logic intr, logic [5:0] fl, logic priv, logic [1:0] plv);
        commit_pkg::cause_t exp;
        @(posedge clk);
        clear_inputs();
        valid0_i <= 1'b1;
        flags0_i <= fl;
        interrupt_i <= intr;
        privileged0_i <= priv;
        crmd_plv_i <= plv;
        {pc_cause0_i, ibuf_cause0_i, dec_cause0_i} <= {rc[0], rc[1], rc[2]};
        {disp_cause0_i, ex_cause0_i, cmt_cause0_i} <= {rc[3], rc[4], rc[5]};
        @(negedge clk);
        exp = expected_cause(intr, fl, priv, plv);
        check("cause_priority excp", 32'(intr || (|fl)), 32'(is_exception_o));
        check("cause_priority cause", 32'(exp), 32'(excp_cause_o));
        check("cause_priority ecode", expected_ecode(exp), 32'(ecode_o));
        check("cause_priority esub", (exp == commit_pkg::CAUSE_ADEM) ? 32'd1 : 32'd0,
              32'(esub_o));
    endtask

    task automatic test_cause_priority();
        int e0;
        logic [31:0] r;
        e0 = errors;
        for (int n = 0; n < 40; n++) begin
            for (int k = 0; k < 6; k++) begin
                r = lcg_next();
                rc[k] = commit_pkg::cause_t'({3'b000, r[3:0]});  // never NOP
            end
            r = lcg_next();
            cause_case(r[10:8] == 3'd0, r[5:0], r[6], r[13:12]);
        end
        cause_case(1'b1, 6'b000000, 1'b0, 2'd0);
        rc[2] = commit_pkg::CAUSE_INE;
        cause_case(1'b0, 6'b001011, 1'b1, 2'd3);  // ipe substitution
        cause_case(1'b0, 6'b001000, 1'b1, 2'd0);  // plv0 keeps decode cause
        rc[5] = commit_pkg::CAUSE_ADEM;
        cause_case(1'b0, 6'b000001, 1'b0, 2'd0);
        report("cause_priority", e0);
    endtask

    // one cycle of redirect stimulus; slot traps use the commit-stage flag
    task automatic redirect_case(logic t0, logic t1, commit_pkg::cause_t c,
                                 logic ertn, logic csr, logic br, logic exf);
        @(posedge clk);
        clear_inputs();
        {valid0_i, valid1_i} <= 2'b11;
        flags0_i <= {5'd0, t0};
        flags1_i <= {5'd0, t1};
        cmt_cause0_i <= c;
        cmt_cause1_i <= c;
        {pc0_i, pc1_i, addr0_i, addr1_i} <= {32'h1000, 32'h1004, 32'ha000, 32'hb000};
        {eentry_i, tlbrentry_i, era_i} <= {32'h8000_0000, 32'h8000_1000, 32'h2000};
        {refetch_pc_i, branch_pc_i} <= {32'h3000, 32'h4000};
        {ertn0_i, branch_flush_i, ex_flush_i} <= {ertn, br, exf};
        csr_we_i <= {1'b0, csr};
        @(negedge clk);
    endtask

    task automatic test_redirect();
        int e0;
        e0 = errors;
        redirect_case(1'b1, 1'b1, commit_pkg::CAUSE_SYS, 0, 0, 0, 0);
        check("redirect pc both", 32'h1000, excp_pc_o);
        check("redirect addr both", 32'ha000, excp_addr_o);
        redirect_case(1'b0, 1'b1, commit_pkg::CAUSE_SYS, 0, 0, 0, 0);
        check("redirect pc slot1", 32'h1004, excp_pc_o);
        check("redirect addr slot1", 32'hb000, excp_addr_o);
        check("redirect eentry", 32'h8000_0000, new_pc_o);
        redirect_case(1'b1, 1'b0, commit_pkg::CAUSE_TLBR, 1, 1, 1, 0);
        check("redirect tlbr", 32'h8000_1000, new_pc_o);
        redirect_case(1'b0, 1'b0, commit_pkg::CAUSE_SYS, 1, 1, 1, 0);
        check("redirect ertn", 32'h2000, new_pc_o);
        redirect_case(1'b0, 1'b0, commit_pkg::CAUSE_SYS, 0, 1, 1, 0);
        check("redirect refetch", 32'h3000, new_pc_o);
        redirect_case(1'b0, 1'b0, commit_pkg::CAUSE_SYS, 0, 0, 1, 0);
        check("redirect branch", 32'h4000, new_pc_o);
        report("redirect", e0);
    endtask

    task automatic test_flush();
        int e0;
        e0 = errors;
        redirect_case(1'b1, 1'b0, commit_pkg::CAUSE_ALE, 0, 0, 0, 0);
        check("flush exception", 32'hff, 32'(flush_o));
        redirect_case(1'b0, 1'b0, commit_pkg::CAUSE_ALE, 1, 0, 0, 0);
        check("flush ertn", 32'hff, 32'(flush_o));
        redirect_case(1'b0, 1'b0, commit_pkg::CAUSE_ALE, 0, 0, 1, 0);
        check("flush branch", 32'h1f, 32'(flush_o));
        redirect_case(1'b0, 1'b0, commit_pkg::CAUSE_ALE, 0, 0, 0, 1);
        check("flush ex_flush", 32'h18, 32'(flush_o));
        redirect_case(1'b0, 1'b0, commit_pkg::CAUSE_ALE, 0, 1, 0, 0);
        check("flush refetch", 32'hff, 32'(flush_o));
        report("flush", e0);
    endtask

    task automatic gate_case(string name, logic [1:0] trap, logic pmem, logic [4:0] a1,
                             logic [1:0] csr, logic [1:0] ll, logic [1:0] exp_we,
                             logic exp_csr, logic exp_ll);
        logic [31:0] d0, d1;
        d0 = lcg_next();
        d1 = lcg_next();
        @(posedge clk);
        clear_inputs();
        {valid0_i, valid1_i} <= 2'b11;
        flags0_i <= {5'd0, trap[0]};
        flags1_i <= {5'd0, trap[1]};
        {cmt_cause0_i, cmt_cause1_i} <= {commit_pkg::CAUSE_BRK, commit_pkg::CAUSE_BRK};
        rf_we_i <= 2'b11;
        {rf_addr0_i, rf_addr1_i, rf_data0_i, rf_data1_i} <= {5'd3, a1, d0, d1};
        pause_mem_i <= pmem;
        csr_we_i <= csr;
        llsc_i <= ll;
        {csr_addr0_i, csr_addr1_i, csr_data0_i, csr_data1_i} <= {14'h10, 14'h20, d0, d1};
        @(negedge clk);
        check(name, 32'(exp_we), 32'(rf_we_o));
        check(name, 32'd3, 32'(rf_addr0_o));
        check(name, 32'(a1), 32'(rf_addr1_o));
        check(name, d0, rf_data0_o);
        check(name, d1, rf_data1_o);
        check(name, 32'(exp_csr), 32'(csr_we_o));
        check(name, 32'(exp_ll), 32'(llsc_o));
        if (exp_csr) begin
            check(name, csr[0] ? 32'h10 : 32'h20, 32'(csr_addr_o));
            check(name, csr[0] ? d0 : d1, csr_data_o);
            check(name, 32'hff, 32'(flush_o));  // csr write forces refetch
        end
        if (exp_ll && ll[0]) begin
            check(name, 32'hff, 32'(flush_o));  // ll/sc in slot 0 forces refetch
        end
    endtask

    task automatic test_write_gating();
        int e0;
        e0 = errors;
        gate_case("gating clean", 2'b00, 1'b0, 5'd7, 2'b00, 2'b00, 2'b11, 1'b0, 1'b0);
        gate_case("gating trap0", 2'b01, 1'b0, 5'd7, 2'b00, 2'b00, 2'b00, 1'b0, 1'b0);
        gate_case("gating trap1", 2'b10, 1'b0, 5'd7, 2'b00, 2'b00, 2'b01, 1'b0, 1'b0);
        gate_case("gating mem pause", 2'b00, 1'b1, 5'd7, 2'b00, 2'b00, 2'b00, 1'b0, 1'b0);
        gate_case("gating same addr", 2'b00, 1'b0, 5'd3, 2'b00, 2'b00, 2'b10, 1'b0, 1'b0);
        gate_case("gating csr both", 2'b00, 1'b0, 5'd7, 2'b11, 2'b00, 2'b11, 1'b1, 1'b0);
        gate_case("gating csr slot1", 2'b00, 1'b0, 5'd7, 2'b10, 2'b00, 2'b11, 1'b1, 1'b0);
        gate_case("gating csr trap", 2'b10, 1'b0, 5'd7, 2'b11, 2'b00, 2'b01, 1'b0, 1'b0);
        gate_case("gating llsc slot0", 2'b00, 1'b0, 5'd7, 2'b00, 2'b01, 2'b11, 1'b0, 1'b1);
        gate_case("gating llsc trap", 2'b01, 1'b0, 5'd7, 2'b00, 2'b11, 2'b00, 1'b0, 1'b0);
        report("write_gating", e0);
    endtask

    task automatic test_pause();
        int e0;
        int n;
        e0 = errors;
        @(negedge clk);
        check("pause after reset", 32'd0, 32'(pause_o[1:0]));
        for (int s = 0; s < 4; s++) begin
            @(posedge clk);
            clear_inputs();
            {pause_mem_i, pause_execute_i, pause_dispatch_i, pause_decode_i} <= 4'b1000 >> s;
            @(negedge clk);
            case (s)
                0: check("pause mem", 32'hf0, 32'(pause_o));
                1: check("pause execute", 32'h70, 32'(pause_o));
                2: check("pause dispatch", 32'h30, 32'(pause_o));
                default: check("pause decode", 32'h1c, 32'(pause_o));
            endcase
        end
        @(posedge clk);
        clear_inputs();
        idle0_i <= 1'b1;
        @(negedge clk);
        check("idle commit same cycle", 32'd0, 32'(pause_o[1:0]));
        @(posedge clk);
        idle0_i <= 1'b0;
        n = 1;
        @(negedge clk);
        while (!pause_o[0] && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!pause_o[0]) begin
            $display("idle lock never set after idle commit");
            errors++;
        end
        check("idle lock latency", 32'd1, 32'(n));
        check("idle lock bits", 32'd3, 32'(pause_o[1:0]));
        @(posedge clk);
        branch_flush_i <= 1'b1;
        @(negedge clk);
        check("idle lock with branch", 32'd1, 32'(pause_o[1:0]));
        @(posedge clk);
        branch_flush_i <= 1'b0;
        interrupt_i <= 1'b1;
        @(negedge clk);
        check("idle lock at interrupt", 32'd3, 32'(pause_o[1:0]));
        @(posedge clk);
        interrupt_i <= 1'b0;
        @(negedge clk);
        check("idle lock after interrupt", 32'd0, 32'(pause_o[1:0]));
        report("pause", e0);
    endtask

    initial begin
        rst = 1'b1;
        clear_inputs();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_pause();
        test_cause_priority();
        test_redirect();
        test_flush();
        test_write_gating();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
